// ==== dsa_pkg.sv ====
// dsa engine package: word size, prime, memory map, microcode and bus types
package dsa_pkg;

    // ------------------------------
    // sizes and modulus
    // ------------------------------
    localparam int WORD_W  = 16;
    localparam int MEM_AW  = 4;
    localparam int PROG_AW = 5;   // 32 microcode lines

    localparam logic [WORD_W-1:0] PRIME = 16'd65521;   // largest 16-bit prime

    // ------------------------------
    // operand memory map
    // ------------------------------
    localparam logic [MEM_AW-1:0] ADDR_X   = 4'd0;
    localparam logic [MEM_AW-1:0] ADDR_Y   = 4'd1;
    localparam logic [MEM_AW-1:0] ADDR_Z   = 4'd2;
    localparam logic [MEM_AW-1:0] ADDR_R   = 4'd3;   // reference word for check
    localparam logic [MEM_AW-1:0] ADDR_RES = 4'd8;

    // program entry points in the microcode rom
    localparam logic [PROG_AW-1:0] PROG_MULADD_S = 5'd0;
    localparam logic [PROG_AW-1:0] PROG_MULSUB_S = 5'd8;
    localparam logic [PROG_AW-1:0] PROG_CHECK_S  = 5'd16;

    // ------------------------------
    // encodings
    // ------------------------------
    typedef enum logic [2:0] {
        UOP_NOP,
        UOP_LOAD_A,
        UOP_LOAD_B,
        UOP_EXEC,
        UOP_STORE,
        UOP_CMP,
        UOP_END
    } dsa_uop_e;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL
    } dsa_arith_op_e;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_MULADD,
        CMD_MULSUB,
        CMD_CHECK
    } dsa_cmd_e;

    // one microcode line, 9 bits
    typedef struct packed {
        dsa_uop_e            uop;
        dsa_arith_op_e       op;
        logic [MEM_AW-1:0]   addr;
    } dsa_instr_t;

    // operand memory access, 22 bits
    typedef struct packed {
        logic                we;
        logic                re;
        logic [MEM_AW-1:0]   addr;
        logic [WORD_W-1:0]   wdata;
    } dsa_mem_req_t;

endpackage

// ==== dsa_prog_rom.sv ====
// microcode rom with the muladd, mulsub and check programs, registered output
module dsa_prog_rom (
    input  logic                          clk,
    input  logic [dsa_pkg::PROG_AW-1:0]   addr_i,
    output dsa_pkg::dsa_instr_t           instr_o
);
    import dsa_pkg::*;

    dsa_instr_t rom_line;

    function automatic dsa_instr_t mk_line(input dsa_uop_e uop, input dsa_arith_op_e op,
                                           input logic [MEM_AW-1:0] addr);
        dsa_instr_t l;
        l.uop  = uop;
        l.op   = op;
        l.addr = addr;
        return l;
    endfunction

    always_comb begin
        case (addr_i)
            // ------------------------------
            // muladd: x*y + z
            // ------------------------------
            PROG_MULADD_S + 5'd0: rom_line = mk_line(UOP_LOAD_A, OP_ADD, ADDR_X);
            PROG_MULADD_S + 5'd1: rom_line = mk_line(UOP_LOAD_B, OP_ADD, ADDR_Y);
            PROG_MULADD_S + 5'd2: rom_line = mk_line(UOP_EXEC,   OP_MUL, ADDR_X);
            PROG_MULADD_S + 5'd3: rom_line = mk_line(UOP_LOAD_B, OP_ADD, ADDR_Z);
            PROG_MULADD_S + 5'd4: rom_line = mk_line(UOP_EXEC,   OP_ADD, ADDR_X);
            PROG_MULADD_S + 5'd5: rom_line = mk_line(UOP_STORE,  OP_ADD, ADDR_RES);
            PROG_MULADD_S + 5'd6: rom_line = mk_line(UOP_END,    OP_ADD, ADDR_X);
            // ------------------------------
            // mulsub: x*y - z
            // ------------------------------
            PROG_MULSUB_S + 5'd0: rom_line = mk_line(UOP_LOAD_A, OP_ADD, ADDR_X);
            PROG_MULSUB_S + 5'd1: rom_line = mk_line(UOP_LOAD_B, OP_ADD, ADDR_Y);
            PROG_MULSUB_S + 5'd2: rom_line = mk_line(UOP_EXEC,   OP_MUL, ADDR_X);
            PROG_MULSUB_S + 5'd3: rom_line = mk_line(UOP_LOAD_B, OP_ADD, ADDR_Z);
            PROG_MULSUB_S + 5'd4: rom_line = mk_line(UOP_EXEC,   OP_SUB, ADDR_X);
            PROG_MULSUB_S + 5'd5: rom_line = mk_line(UOP_STORE,  OP_ADD, ADDR_RES);
            PROG_MULSUB_S + 5'd6: rom_line = mk_line(UOP_END,    OP_ADD, ADDR_X);
            // ------------------------------
            // check: x*y against r
            // ------------------------------
            PROG_CHECK_S + 5'd0:  rom_line = mk_line(UOP_LOAD_A, OP_ADD, ADDR_X);
            PROG_CHECK_S + 5'd1:  rom_line = mk_line(UOP_LOAD_B, OP_ADD, ADDR_Y);
            PROG_CHECK_S + 5'd2:  rom_line = mk_line(UOP_EXEC,   OP_MUL, ADDR_X);
            PROG_CHECK_S + 5'd3:  rom_line = mk_line(UOP_STORE,  OP_ADD, ADDR_RES);
            PROG_CHECK_S + 5'd4:  rom_line = mk_line(UOP_CMP,    OP_ADD, ADDR_R);
            PROG_CHECK_S + 5'd5:  rom_line = mk_line(UOP_END,    OP_ADD, ADDR_X);
            default:              rom_line = mk_line(UOP_END,    OP_ADD, ADDR_X);  // stray pc ends
        endcase
    end

    always_ff @(posedge clk) begin
        instr_o <= rom_line;
    end

endmodule

// ==== dsa_ctrl.sv ====
// program sequencer: fetches micro-ops, drives memory and arithmetic unit, keeps status
module dsa_ctrl (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start_i,
    input  dsa_pkg::dsa_cmd_e             cmd_i,
    output logic [dsa_pkg::PROG_AW-1:0]   rom_addr_o,
    input  dsa_pkg::dsa_instr_t           instr_i,
    output dsa_pkg::dsa_mem_req_t         mem_req_o,
    input  logic [dsa_pkg::WORD_W-1:0]    mem_rdata_i,
    output logic                          load_a_o,
    output logic                          load_b_o,
    output logic                          exec_o,
    output dsa_pkg::dsa_arith_op_e        op_o,
    input  logic                          arith_busy_i,
    input  logic [dsa_pkg::WORD_W-1:0]    result_i,
    output logic                          ready_o,
    output logic                          valid_o,
    output logic                          verify_o
);
    import dsa_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,   // rom line valid, issue the micro-op
        S_MEM,     // read data returning
        S_ARITH    // arithmetic unit running
    } state_e;

    state_e             state_q;
    state_e             state_d;
    logic [PROG_AW-1:0] pc_q;
    logic [PROG_AW-1:0] entry;
    dsa_uop_e           wait_uop_q;   // micro-op that owns the memory wait
    logic               cmp_hit_q;
    logic               start_ok;

    assign start_ok = (state_q == S_IDLE) && start_i && (cmd_i != CMD_NONE);
    assign ready_o  = (state_q == S_IDLE);

    always_comb begin
        case (cmd_i)
            CMD_MULSUB: entry = PROG_MULSUB_S;
            CMD_CHECK:  entry = PROG_CHECK_S;
            default:    entry = PROG_MULADD_S;
        endcase
    end

    // ------------------------------
    // next state and strobes
    // ------------------------------
    always_comb begin
        state_d    = state_q;
        rom_addr_o = pc_q;   // hold the next line during waits
        mem_req_o  = '0;
        load_a_o   = 1'b0;
        load_b_o   = 1'b0;
        exec_o     = 1'b0;
        op_o       = instr_i.op;
        case (state_q)
            S_IDLE: begin
                rom_addr_o = entry;
                if (start_ok) state_d = S_FETCH;
            end
            S_FETCH: begin
                rom_addr_o = pc_q + 1'b1;
                case (instr_i.uop)
                    UOP_LOAD_A, UOP_LOAD_B, UOP_CMP: begin
                        mem_req_o.re   = 1'b1;
                        mem_req_o.addr = instr_i.addr;
                        state_d        = S_MEM;
                    end
                    UOP_STORE: begin
                        mem_req_o.we    = 1'b1;
                        mem_req_o.addr  = instr_i.addr;
                        mem_req_o.wdata = result_i;
                    end
                    UOP_EXEC: begin
                        exec_o  = 1'b1;
                        state_d = S_ARITH;
                    end
                    UOP_END: state_d = S_IDLE;
                    UOP_NOP: ;
                    default: state_d = S_IDLE;   // unknown encoding
                endcase
            end
            S_MEM: begin
                load_a_o = (wait_uop_q == UOP_LOAD_A);
                load_b_o = (wait_uop_q == UOP_LOAD_B);
                state_d  = S_FETCH;
            end
            S_ARITH: begin
                if (!arith_busy_i) state_d = S_FETCH;   // stall pc while mul runs
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q    <= S_IDLE;
            pc_q       <= '0;
            wait_uop_q <= UOP_NOP;
            cmp_hit_q  <= 1'b0;
            valid_o    <= 1'b0;
            verify_o   <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= rom_addr_o;
            if (state_q == S_FETCH) wait_uop_q <= instr_i.uop;
            if (start_ok) begin
                valid_o   <= 1'b0;
                verify_o  <= 1'b0;
                cmp_hit_q <= 1'b0;
            end
            if (state_q == S_MEM && wait_uop_q == UOP_CMP) begin
                cmp_hit_q <= (mem_rdata_i == result_i);
            end
            // verify published together with valid
            if (state_q == S_FETCH && instr_i.uop == UOP_END) begin
                valid_o  <= 1'b1;
                verify_o <= cmp_hit_q;
            end
        end
    end

    // the arithmetic unit must be idle whenever the program issues an exec
    a_exec_not_busy: assert property (@(posedge clk) disable iff (!reset_n)
        exec_o |-> !arith_busy_i);

endmodule

// ==== dsa_arith_unit.sv ====
// arithmetic unit: operand registers, modular add and sub, serial modular multiplier
module dsa_arith_unit (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          load_a_i,
    input  logic                          load_b_i,
    input  logic [dsa_pkg::WORD_W-1:0]    data_i,
    input  logic                          exec_i,
    input  dsa_pkg::dsa_arith_op_e        op_i,
    output logic [dsa_pkg::WORD_W-1:0]    result_o,
    output logic                          busy_o
);
    import dsa_pkg::*;

    logic [WORD_W-1:0]         a_q;
    logic [WORD_W-1:0]         b_q;
    logic [WORD_W-1:0]         acc_q;
    logic [WORD_W-1:0]         acc_dbl;
    logic [WORD_W-1:0]         acc_step;
    logic [$clog2(WORD_W)-1:0] bit_q;   // msb first

    // operands below PRIME, so one correction is enough
    function automatic logic [WORD_W-1:0] mod_add(input logic [WORD_W-1:0] a,
                                                  input logic [WORD_W-1:0] b);
        logic [WORD_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, PRIME}) sum = sum - {1'b0, PRIME};
        return sum[WORD_W-1:0];
    endfunction

    function automatic logic [WORD_W-1:0] mod_sub(input logic [WORD_W-1:0] a,
                                                  input logic [WORD_W-1:0] b);
        logic [WORD_W:0] diff;
        diff = {1'b0, a} - {1'b0, b};
        if (a < b) diff = diff + {1'b0, PRIME};   // wrapped below zero
        return diff[WORD_W-1:0];
    endfunction

    // one double-and-add step per cycle
    assign acc_dbl  = mod_add(acc_q, acc_q);
    assign acc_step = b_q[bit_q] ? mod_add(acc_dbl, a_q) : acc_dbl;
    assign result_o = a_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy_o <= 1'b0;
            bit_q  <= '0;
        end else if (exec_i && op_i == OP_MUL) begin
            busy_o <= 1'b1;
            bit_q  <= '1;
        end else if (busy_o) begin
            bit_q <= bit_q - 1'b1;
            if (bit_q == '0) busy_o <= 1'b0;
        end
    end

    // ------------------------------
    // operands and accumulator
    // ------------------------------
    always_ff @(posedge clk) begin
        if (load_a_i) a_q <= data_i;
        if (load_b_i) b_q <= data_i;
        if (exec_i) begin
            case (op_i)
                OP_ADD:  a_q <= mod_add(a_q, b_q);
                OP_SUB:  a_q <= mod_sub(a_q, b_q);
                OP_MUL:  acc_q <= '0;
                default: ;
            endcase
        end else if (busy_o) begin
            acc_q <= acc_step;
            if (bit_q == '0) a_q <= acc_step;   // product replaces a for chaining
        end
    end

    // operands stay frozen for the whole multiply
    a_no_touch_busy: assert property (@(posedge clk) disable iff (!reset_n)
        busy_o |-> !(exec_i || load_a_i || load_b_i));

endmodule

// ==== dsa_mem_arb.sv ====
// operand memory, 16 words, shared by sequencer and host with sequencer priority
module dsa_mem_arb (
    input  logic                          clk,
    input  logic                          reset_n,
    input  dsa_pkg::dsa_mem_req_t         seq_req_i,
    input  dsa_pkg::dsa_mem_req_t         host_req_i,
    output logic                          host_gnt_o,
    output logic [dsa_pkg::WORD_W-1:0]    rdata_o
);
    import dsa_pkg::*;

    logic [WORD_W-1:0] mem_q [0:2**MEM_AW-1];
    logic              seq_act;
    dsa_mem_req_t      sel_req;   // the one access done this cycle

    assign seq_act    = seq_req_i.we || seq_req_i.re;
    assign host_gnt_o = !seq_act && (host_req_i.we || host_req_i.re);
    assign sel_req    = seq_act ? seq_req_i : host_req_i;

    always_ff @(posedge clk) begin
        if (sel_req.we) mem_q[sel_req.addr] <= sel_req.wdata;
        if (sel_req.re) rdata_o <= mem_q[sel_req.addr];   // data one cycle after grant
    end

    // a host access is performed once, the port drops it after the grant
    a_one_access_per_grant: assert property (@(posedge clk) disable iff (!reset_n)
        host_gnt_o |=> !host_gnt_o);

endmodule

// ==== dsa_host_port.sv ====
// host port: holds one access until granted, then acknowledges with read data
module dsa_host_port (
    input  logic                          clk,
    input  logic                          reset_n,
    input  dsa_pkg::dsa_mem_req_t         req_i,
    input  logic                          gnt_i,
    input  logic [dsa_pkg::WORD_W-1:0]    mem_rdata_i,
    output dsa_pkg::dsa_mem_req_t         mem_req_o,
    output logic                          ack_o,
    output logic [dsa_pkg::WORD_W-1:0]    rdata_o
);
    import dsa_pkg::*;

    dsa_mem_req_t      req_q;
    logic              pending_q;
    logic [WORD_W-1:0] rdata_q;
    logic              new_req;
    logic              rd_ack;

    assign new_req   = req_i.we || req_i.re;
    assign rd_ack    = ack_o && req_q.re;
    assign mem_req_o = pending_q ? req_q : '0;
    assign rdata_o   = rd_ack ? mem_rdata_i : rdata_q;   // hold last read after ack

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pending_q <= 1'b0;
            ack_o     <= 1'b0;
        end else begin
            ack_o <= pending_q && gnt_i;
            if (pending_q && gnt_i) pending_q <= 1'b0;
            else if (new_req)       pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!pending_q && new_req) req_q <= req_i;
        if (rd_ack) rdata_q <= mem_rdata_i;
    end

    // host waits for the ack before the next access
    a_no_req_while_pending: assert property (@(posedge clk) disable iff (!reset_n)
        new_req |-> !pending_q);

endmodule

// ==== dsa_top.sv ====
// dsa engine top: sequencer, microcode rom, arithmetic unit, memory arbiter and host port
module dsa_top (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start_i,
    input  dsa_pkg::dsa_cmd_e             cmd_i,
    input  dsa_pkg::dsa_mem_req_t         host_req_i,
    output logic                          host_ack_o,
    output logic [dsa_pkg::WORD_W-1:0]    host_rdata_o,
    output logic                          ready_o,
    output logic                          valid_o,
    output logic                          verify_o
);
    import dsa_pkg::*;

    logic [PROG_AW-1:0] rom_addr;
    dsa_instr_t         instr;
    dsa_mem_req_t       seq_req;
    dsa_mem_req_t       host_mem_req;
    logic [WORD_W-1:0]  mem_rdata;
    logic [WORD_W-1:0]  result;
    logic               load_a;
    logic               load_b;
    logic               exec;
    logic               arith_busy;
    logic               host_gnt;
    dsa_arith_op_e      op;

    dsa_ctrl ctrl_i (
        .clk(clk), .reset_n(reset_n), .start_i(start_i), .cmd_i(cmd_i),
        .rom_addr_o(rom_addr), .instr_i(instr),
        .mem_req_o(seq_req), .mem_rdata_i(mem_rdata),
        .load_a_o(load_a), .load_b_o(load_b), .exec_o(exec), .op_o(op),
        .arith_busy_i(arith_busy), .result_i(result),
        .ready_o(ready_o), .valid_o(valid_o), .verify_o(verify_o)
    );

    dsa_prog_rom rom_i (.clk(clk), .addr_i(rom_addr), .instr_o(instr));

    // operands load straight from memory read data
    dsa_arith_unit arith_i (
        .clk(clk), .reset_n(reset_n), .load_a_i(load_a), .load_b_i(load_b),
        .data_i(mem_rdata), .exec_i(exec), .op_i(op),
        .result_o(result), .busy_o(arith_busy)
    );

    dsa_mem_arb arb_i (
        .clk(clk), .reset_n(reset_n), .seq_req_i(seq_req), .host_req_i(host_mem_req),
        .host_gnt_o(host_gnt), .rdata_o(mem_rdata)
    );

    dsa_host_port host_i (
        .clk(clk), .reset_n(reset_n), .req_i(host_req_i), .gnt_i(host_gnt),
        .mem_rdata_i(mem_rdata), .mem_req_o(host_mem_req),
        .ack_o(host_ack_o), .rdata_o(host_rdata_o)
    );

endmodule

// ==== tb_dsa_checker.sv ====
// dsa checker that mirrors host writes, predicts command results and compares DUT outputs
module tb_dsa_checker (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start_i,
    input  dsa_pkg::dsa_cmd_e             cmd_i,
    input  dsa_pkg::dsa_mem_req_t         host_req_i,
    input  logic                          host_ack_i,
    input  logic [dsa_pkg::WORD_W-1:0]    host_rdata_i,
    input  logic                          ready_i,
    input  logic                          valid_i,
    input  logic                          verify_i,
    output int                            errors_o,
    output int                            checks_o,
    output int                            completions_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import dsa_pkg::*;

    localparam longint unsigned MODULUS = 65521;

    logic [WORD_W-1:0] model_mem [0:2**MEM_AW-1];
    dsa_mem_req_t      last_req;
    dsa_cmd_e          run_cmd;
    logic              running    = 1'b0;
    logic              valid_q    = 1'b0;
    logic              reset_seen = 1'b0;

    initial begin
        errors_o      = 0;
        checks_o      = 0;
        completions_o = 0;
    end

    function automatic logic [WORD_W-1:0] expected_result(input dsa_cmd_e cmd,
            input logic [WORD_W-1:0] x, input logic [WORD_W-1:0] y,
            input logic [WORD_W-1:0] z);
        longint unsigned prod;
        longint unsigned res;
        prod = (64'(x) * 64'(y)) % MODULUS;
        case (cmd)
            CMD_MULADD: res = (prod + 64'(z)) % MODULUS;
            CMD_MULSUB: res = (prod + MODULUS - 64'(z)) % MODULUS;
            default:    res = prod;
        endcase
        return res[WORD_W-1:0];
    endfunction

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks_o++;
        if (got !== exp) begin
            errors_o++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ------------------------------
    // compare at the falling edge
    // ------------------------------
    always @(negedge clk) begin
        logic [WORD_W-1:0] exp_res;
        logic              exp_ver;
        if (!reset_n) begin
            running    = 1'b0;
            valid_q    = 1'b0;
            reset_seen = 1'b1;
        end else begin
            if (reset_seen) begin   // first cycle out of reset
                compare_bit("ready_o", ready_i, 1'b1);
                compare_bit("valid_o", valid_i, 1'b0);
                compare_bit("verify_o", verify_i, 1'b0);
                compare_bit("host_ack_o", host_ack_i, 1'b0);
                reset_seen = 1'b0;
            end
            if (host_req_i.we || host_req_i.re) last_req = host_req_i;
            if (host_ack_i) begin
                if (last_req.we) model_mem[last_req.addr] = last_req.wdata;
                else begin
                    checks_o++;
                    if (host_rdata_i !== model_mem[last_req.addr]) begin
                        errors_o++;
                        $display("error host_rdata_o at addr %h: got %h, expected %h",
                                 last_req.addr, host_rdata_i, model_mem[last_req.addr]);
                    end
                end
            end
            if (start_i && ready_i && cmd_i != CMD_NONE) begin
                running = 1'b1;
                run_cmd = cmd_i;
            end
            if (valid_i && !valid_q) begin
                completions_o++;
                compare_bit("ready_o", ready_i, 1'b1);   // idle again on completion
                if (!running) begin
                    errors_o++;
                    $display("a completion was seen without an accepted start");
                end else begin
                    exp_res = expected_result(run_cmd, model_mem[ADDR_X], model_mem[ADDR_Y],
                                              model_mem[ADDR_Z]);
                    exp_ver = (run_cmd == CMD_CHECK) && (exp_res == model_mem[ADDR_R]);
                    model_mem[ADDR_RES] = exp_res;   // read back later by the host
                    compare_bit("verify_o", verify_i, exp_ver);
                end
                running = 1'b0;
            end
            valid_q = valid_i;
        end
    end

endmodule

// ==== tb_dsa_top.sv ====
// dsa engine testbench top with clock, reset, stimulus table, host accesses and command runs
module tb_dsa_top;
    timeunit 1ns;
    timeprecision 100ps;
    import dsa_pkg::*;

    localparam int ROWS        = 16;
    localparam int FIXED_ROWS  = 8;
    localparam int CYCLE_LIMIT = ROWS * 300;
    localparam logic [MEM_AW-1:0] ADDR_SPARE = 4'd12;   // not touched by the programs

    typedef enum logic [1:0] {
        MODE_PLAIN,
        MODE_HOST_BUSY,   // host write while the command runs
        MODE_RESTART      // extra start while busy
    } mode_e;

    typedef struct packed {
        dsa_cmd_e          cmd;
        logic [WORD_W-1:0] x;
        logic [WORD_W-1:0] y;
        logic [WORD_W-1:0] z;
        logic [WORD_W-1:0] r;
        mode_e             mode;
    } row_t;

    logic              clk;
    logic              reset_n;
    logic              start;
    dsa_cmd_e          cmd_in;
    dsa_mem_req_t      host_req;
    logic              host_ack;
    logic [WORD_W-1:0] host_rdata;
    logic              ready;
    logic              valid;
    logic              verify;
    int                chk_errors;
    int                chk_checks;
    int                completions;
    int                tb_errors;
    int                cycles;
    logic [31:0]       lfsr_state;
    row_t              stim [ROWS];

    dsa_top dut_i (
        .clk(clk), .reset_n(reset_n), .start_i(start), .cmd_i(cmd_in),
        .host_req_i(host_req), .host_ack_o(host_ack), .host_rdata_o(host_rdata),
        .ready_o(ready), .valid_o(valid), .verify_o(verify)
    );

    tb_dsa_checker chk_i (
        .clk(clk), .reset_n(reset_n), .start_i(start), .cmd_i(cmd_in),
        .host_req_i(host_req), .host_ack_i(host_ack), .host_rdata_i(host_rdata),
        .ready_i(ready), .valid_i(valid), .verify_i(verify),
        .errors_o(chk_errors), .checks_o(chk_checks), .completions_o(completions)
    );

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped responding", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [WORD_W-1:0] lfsr_bits(input int n);
        logic [WORD_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[WORD_W-2:0], lfsr_state[0]};
            if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else               lfsr_state = lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic row_t make_row(input dsa_cmd_e c, input logic [WORD_W-1:0] x,
                                      input logic [WORD_W-1:0] y, input logic [WORD_W-1:0] z,
                                      input logic [WORD_W-1:0] r, input mode_e m);
        row_t row;
        row.cmd  = c;
        row.x    = x;
        row.y    = y;
        row.z    = z;
        row.r    = r;
        row.mode = m;
        return row;
    endfunction

    // ------------------------------
    // stimulus table
    // ------------------------------
    task automatic fill_table();
        dsa_cmd_e          c;
        logic [WORD_W-1:0] pick;
        logic [WORD_W-1:0] rx;
        logic [WORD_W-1:0] ry;
        logic [WORD_W-1:0] rz;
        logic [WORD_W-1:0] rr;
        stim[0] = make_row(CMD_MULADD, 16'd3,     16'd5,     16'd7,     16'd0, MODE_PLAIN);
        stim[1] = make_row(CMD_MULSUB, 16'd2,     16'd3,     16'd10,    16'd0, MODE_PLAIN);
        stim[2] = make_row(CMD_MULADD, 16'd0,     16'd1234,  16'd65520, 16'd0, MODE_PLAIN);
        stim[3] = make_row(CMD_MULSUB, 16'd65520, 16'd65520, 16'd0,     16'd0, MODE_PLAIN);
        stim[4] = make_row(CMD_CHECK,  16'd300,   16'd400,   16'd0,  16'd54479, MODE_HOST_BUSY);
        stim[5] = make_row(CMD_CHECK,  16'd65520, 16'd2,     16'd0,  16'h1234,  MODE_RESTART);
        stim[6] = make_row(CMD_MULADD, 16'd65520, 16'd65520, 16'd65520, 16'd0, MODE_PLAIN);
        stim[7] = make_row(CMD_MULSUB, 16'd1000,  16'd0,     16'd1,     16'd0, MODE_RESTART);
        for (int i = FIXED_ROWS; i < ROWS; i++) begin
            pick = lfsr_bits(2);
            c    = dsa_cmd_e'(pick[1:0]);
            if (c == CMD_NONE) c = CMD_CHECK;
            rx = lfsr_bits(15);   // 15 bits keeps all below the prime
            ry = lfsr_bits(15);
            rz = lfsr_bits(15);
            rr = lfsr_bits(15);
            stim[i] = make_row(c, rx, ry, rz, rr, MODE_PLAIN);
        end
    endtask

    task automatic host_access(input logic we, input logic [MEM_AW-1:0] addr,
                               input logic [WORD_W-1:0] data);
        @(posedge clk);
        #2;
        host_req.we    = we;
        host_req.re    = !we;
        host_req.addr  = addr;
        host_req.wdata = data;
        @(posedge clk);
        #2;
        host_req = '0;
        while (!host_ack) @(negedge clk);
    endtask

    task automatic pulse_start(input dsa_cmd_e c);
        @(posedge clk);
        #2;
        start  = 1'b1;
        cmd_in = c;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic run_row(input row_t row);
        host_access(1'b1, ADDR_X, row.x);
        host_access(1'b1, ADDR_Y, row.y);
        host_access(1'b1, ADDR_Z, row.z);
        host_access(1'b1, ADDR_R, row.r);
        pulse_start(row.cmd);
        if (row.mode == MODE_HOST_BUSY) host_access(1'b1, ADDR_SPARE, row.x ^ row.y);
        if (row.mode == MODE_RESTART) begin
            @(posedge clk);
            #2;
            if (ready) begin
                tb_errors++;
                $display("engine was already idle when the extra start was issued");
            end
            start  = 1'b1;
            cmd_in = (row.cmd == CMD_CHECK) ? CMD_MULADD : CMD_CHECK;
            @(posedge clk);
            #2;
            start = 1'b0;
        end
        while (!valid) @(negedge clk);
        if (row.mode == MODE_HOST_BUSY) host_access(1'b0, ADDR_SPARE, '0);
        host_access(1'b0, ADDR_RES, '0);
    endtask

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        start      = 1'b0;
        cmd_in     = CMD_NONE;
        host_req   = '0;
        tb_errors  = 0;
        cycles     = 0;
        lfsr_state = 32'h6c0b;
        fill_table();
        repeat (3) @(posedge clk);
        #2 reset_n = 1'b1;
        host_access(1'b1, ADDR_SPARE, 16'ha5c3);   // write then read back while idle
        host_access(1'b0, ADDR_SPARE, '0);
        for (int i = 0; i < ROWS; i++) run_row(stim[i]);
        repeat (4) @(posedge clk);
        if (completions != ROWS) begin
            tb_errors++;
            $display("expected %0d command completions but saw %0d", ROWS, completions);
        end
        $display("%0d checks, %0d checker errors, %0d sequence errors",
                 chk_checks, chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) $display("No errors");
        else                             $display("Errors found");
        $finish;
    end

endmodule

// ==== build.f ====
dsa_pkg.sv
dsa_prog_rom.sv
dsa_ctrl.sv
dsa_arith_unit.sv
dsa_mem_arb.sv
dsa_host_port.sv
dsa_top.sv
tb_dsa_checker.sv
tb_dsa_top.sv
